// File: hw/video_timing_pkg.sv
// raster geometry constants and coordinate types for the video back end
package video_timing_pkg;

	// ======================================================================
	// horizontal geometry, counted in pixel clocks
	// ======================================================================
	localparam int H_TOTAL      = 384;	// pixels per line incl. blanking
	localparam int H_ACTIVE     = 256;	// visible pixels
	localparam int H_SYNC_START = 296;
	localparam int H_SYNC_END   = 328;	// first pixel after sync

	// ======================================================================
	// vertical geometry, counted in lines
	// ======================================================================
	localparam int V_TOTAL      = 264;	// lines per frame
	localparam int V_ACTIVE     = 224;	// visible lines
	localparam int V_SYNC_START = 240;
	localparam int V_SYNC_END   = 248;	// first line after sync

	// coordinate types
	typedef logic [8:0] hcount_t;	// pixel in line, 0..383
	typedef logic [8:0] vcount_t;	// line in frame, 0..263
	typedef logic [7:0] vpix_t;	// low byte of line, flip applied

	// scroll register selects from the low two bits of the cpu write address
	localparam logic [1:0] SCRL_SEL_H_LO = 2'd0;	// hscroll[7:0]
	localparam logic [1:0] SCRL_SEL_H_HI = 2'd1;	// hscroll[8]
	localparam logic [1:0] SCRL_SEL_V    = 2'd2;	// vscroll[7:0]
	// select 3 has no register

endpackage

// File: hw/pixel_pkg.sv
// colour code, palette entry and colour gun types for the pixel path
package pixel_pkg;

	// ======================================================================
	// layer colour code
	// ======================================================================
	// one byte read two ways depending on which layer produced it
	typedef union packed {
		// foreground (and background, carried only)
		struct packed {
			logic [5:0] grp;	// colour group
			logic [1:0] idx;	// 0 = see-through
		} fg_view;
		// sprite layer
		struct packed {
			logic [3:0] grp;	// colour group
			logic [3:0] idx;	// 0 = see-through
		} sp_view;
	} colour_code_u;

	// ======================================================================
	// palette
	// ======================================================================
	typedef logic [3:0] gun_t;	// one colour gun, 4 bit dac

	// 12 bit entry, red in the top nibble
	typedef struct packed {
		gun_t red;
		gun_t green;
		gun_t blue;
	} pal_entry_t;

	localparam int PAL_DEPTH = 256;	// one entry per colour code

endpackage

// File: hw/raster_if.sv
// raster position, flip state and visible flag shared by the video stages
`timescale 1ns/1ps

interface raster_if import video_timing_pkg::*; ();

	// all fields come from registers in the timer, same cycle alignment
	hcount_t hpix;		// horizontal pos, flip applied
	vpix_t   vpix;		// vertical pos, flip applied
	logic    flip;		// flip state of current frame
	logic    active;	// inside both visible windows
	logic    line_start;	// first pixel of each line

	// driver side
	modport timer_mp (
		output hpix, vpix, flip, active, line_start
	);

	// scroll adder and mixer side
	modport user_mp (
		input hpix, vpix, flip, active, line_start
	);

endinterface

// File: hw/raster_timer.sv
// raster timer with pixel and line counters, frame flip latch, sync and blank
`timescale 1ns/1ps

module raster_timer import video_timing_pkg::*; (
	input  logic       pixel_clk,
	input  logic       RESET_n,
	input  logic       flip_i,	// screen flip request, any time
	raster_if.timer_mp rif,
	output logic       hsync_o,	// active high
	output logic       vsync_o,	// active high
	output logic       hblank_o,
	output logic       vblank_o
);

	hcount_t hcount;	// raw pixel counter
	vcount_t vcount;	// raw line counter
	logic    line_end;
	logic    frame_end;
	logic    frame_start;	// both counters at zero
	logic    flip_q;	// flip held for the frame
	logic    flip_nxt;

	assign line_end    = (hcount == hcount_t'(H_TOTAL - 1));
	assign frame_end   = (vcount == vcount_t'(V_TOTAL - 1));
	assign frame_start = (hcount == '0) && (vcount == '0);

	// new flip only at frame start, so pixel 0 of line 0 already uses it
	assign flip_nxt = frame_start ? flip_i : flip_q;
	assign rif.flip = flip_q;

	// ======================================================================
	// pixel and line counters
	// ======================================================================
	always_ff @(posedge pixel_clk or negedge RESET_n) begin
		if (!RESET_n) begin
			hcount <= '0;
			vcount <= '0;
		end else begin
			if (line_end) begin
				hcount <= '0;
				vcount <= frame_end ? '0 : vcount + 1'b1;	// wrap at V_TOTAL
			end else begin
				hcount <= hcount + 1'b1;
			end
		end
	end

	// ======================================================================
	// registered coordinates, sync and blank, all from the same count
	// ======================================================================
	always_ff @(posedge pixel_clk or negedge RESET_n) begin
		if (!RESET_n) begin
			flip_q         <= 1'b0;
			rif.hpix       <= '0;
			rif.vpix       <= '0;
			rif.line_start <= 1'b0;
			rif.active     <= 1'b0;
			hblank_o       <= 1'b0;
			vblank_o       <= 1'b0;
			hsync_o        <= 1'b0;
			vsync_o        <= 1'b0;
		end else begin
			flip_q         <= flip_nxt;
			// flipped line runs 383 down to 0
			rif.hpix       <= flip_nxt ? hcount_t'(H_TOTAL - 1) - hcount : hcount;
			rif.vpix       <= flip_nxt ? ~vcount[7:0] : vcount[7:0];	// bitwise invert
			rif.line_start <= (hcount == '0);
			rif.active     <= (hcount < H_ACTIVE) && (vcount < V_ACTIVE);
			// blank and sync use raw counts, never flipped
			hblank_o       <= (hcount >= H_ACTIVE);
			vblank_o       <= (vcount >= V_ACTIVE);
			hsync_o        <= (hcount >= H_SYNC_START) && (hcount < H_SYNC_END);
			vsync_o        <= (vcount >= V_SYNC_START) && (vcount < V_SYNC_END);
		end
	end

	// counters stay inside the raster over all frames
	a_count_range: assert property (@(posedge pixel_clk) disable iff (!RESET_n)
		(hcount < H_TOTAL) && (vcount < V_TOTAL));

endmodule

// File: hw/scroll_adder.sv
// scroll registers and the adders that move the raster position into layer space
`timescale 1ns/1ps

module scroll_adder import video_timing_pkg::*; (
	input  logic       pixel_clk,
	input  logic       RESET_n,
	raster_if.user_mp  rif,
	input  logic       scrl_wr_i,	// one cycle write strobe
	input  logic [1:0] scrl_sel_i,
	input  logic [7:0] scrl_data_i,
	output hcount_t    hscrl_o,	// scrolled x, mod 512
	output vpix_t      vscrl_o	// scrolled y, mod 256
);

	hcount_t hscroll;	// 9 bit horizontal scroll
	vpix_t   vscroll;	// 8 bit vertical scroll

	// cpu writes, new value seen by the adders one cycle later
	always_ff @(posedge pixel_clk or negedge RESET_n) begin
		if (!RESET_n) begin
			hscroll <= '0;
			vscroll <= '0;
		end else if (scrl_wr_i) begin
			case (scrl_sel_i)
				SCRL_SEL_H_LO: hscroll[7:0] <= scrl_data_i;
				SCRL_SEL_H_HI: hscroll[8]   <= scrl_data_i[0];	// only bit 0 used
				SCRL_SEL_V:    vscroll      <= scrl_data_i;
				default: ;
			endcase
		end
	end

	// carry out of the top bit dropped in each adder
	assign hscrl_o = rif.hpix + hscroll;
	assign vscrl_o = rif.vpix + vscroll;

	// select 3 has no register behind it
	a_sel_valid: assert property (@(posedge pixel_clk) disable iff (!RESET_n)
		scrl_wr_i |-> (scrl_sel_i != 2'd3));

endmodule

// File: hw/layer_priority.sv
// three layer priority mixer, foreground over sprites over background
`timescale 1ns/1ps

module layer_priority import pixel_pkg::*; (
	input  logic         pixel_clk,
	input  logic         RESET_n,
	raster_if.user_mp    rif,
	input  colour_code_u fg_pix_i,	// foreground code
	input  colour_code_u sp_pix_i,	// sprite code
	input  colour_code_u bg_pix_i,	// background code, never see-through
	output colour_code_u mix_o,	// winning code, one cycle later
	output logic         mix_active_o	// visible flag aligned with mix_o
);

	logic fg_opaque;
	logic sp_opaque;

	// each layer judged by its own index field
	assign fg_opaque = (fg_pix_i.fg_view.idx != '0);	// 2 bit index
	assign sp_opaque = (sp_pix_i.sp_view.idx != '0);	// 4 bit index

	// ======================================================================
	// colour register
	// ======================================================================
	// winning code loaded every pixel
	always_ff @(posedge pixel_clk) begin
		if (fg_opaque) begin
			mix_o <= fg_pix_i;
		end else if (sp_opaque) begin
			mix_o <= sp_pix_i;
		end else begin
			mix_o <= bg_pix_i;	// background shows through
		end
	end

	// visible flag travels beside the code
	always_ff @(posedge pixel_clk or negedge RESET_n) begin
		if (!RESET_n) begin
			mix_active_o <= 1'b0;
		end else begin
			mix_active_o <= rif.active;
		end
	end

endmodule

// File: hw/palette_ram.sv
// 256 entry colour palette with cpu write port, read register and blank gating
`timescale 1ns/1ps

module palette_ram import pixel_pkg::*; (
	input  logic         pixel_clk,
	input  logic         RESET_n,
	input  colour_code_u mix_i,		// mixed code from the priority stage
	input  logic         mix_active_i,	// low in blanking
	input  logic         pal_wr_i,
	input  logic [7:0]   pal_addr_i,
	input  pal_entry_t   pal_data_i,
	output gun_t         red_o,
	output gun_t         green_o,
	output gun_t         blue_o
);

	pal_entry_t mem [PAL_DEPTH];	// contents unknown until written
	pal_entry_t rgb_q;		// output register

	// ======================================================================
	// write port
	// ======================================================================
	always_ff @(posedge pixel_clk) begin
		if (pal_wr_i) begin
			mem[pal_addr_i] <= pal_data_i;
		end
	end

	// ======================================================================
	// read port, one lookup per pixel
	// ======================================================================
	// same edge read returns the old entry, new one from the next edge
	always_ff @(posedge pixel_clk or negedge RESET_n) begin
		if (!RESET_n) begin
			rgb_q <= '0;
		end else begin
			rgb_q <= mix_active_i ? mem[mix_i] : '0;	// black outside picture
		end
	end

	assign red_o   = rgb_q.red;
	assign green_o = rgb_q.green;
	assign blue_o  = rgb_q.blue;

	// a write with x address would smear the whole palette in simulation
	a_wr_addr_known: assert property (@(posedge pixel_clk) disable iff (!RESET_n)
		pal_wr_i |-> !$isunknown(pal_addr_i));

endmodule

// File: hw/video_core.sv
// video back end top level, raster timing, scroll, layer mix and palette
`timescale 1ns/1ps

module video_core import video_timing_pkg::*, pixel_pkg::*; (
	input  logic       pixel_clk,
	input  logic       RESET_n,
	input  logic       flip_i,		// screen flip, taken at frame start
	// scroll register port
	input  logic       scrl_wr_i,
	input  logic [1:0] scrl_sel_i,
	input  logic [7:0] scrl_data_i,
	// palette write port
	input  logic       pal_wr_i,
	input  logic [7:0] pal_addr_i,
	input  pal_entry_t pal_data_i,
	// layer codes from the tile and sprite engines
	input  logic [7:0] fg_pix_i,
	input  logic [7:0] sp_pix_i,
	input  logic [7:0] bg_pix_i,
	// coordinates for the layer engines
	output hcount_t    hpix_o,
	output vpix_t      vpix_o,
	output hcount_t    hscrl_o,
	output vpix_t      vscrl_o,
	// video out
	output gun_t       red_o,
	output gun_t       green_o,
	output gun_t       blue_o,
	output logic       hsync_o,
	output logic       vsync_o,
	output logic       hblank_o,
	output logic       vblank_o
);

	colour_code_u mix_code;	// priority winner
	logic         mix_active;	// its visible flag

	raster_if rif ();

	// ======================================================================
	// position producers
	// ======================================================================
	raster_timer i_raster_timer (
		.pixel_clk (pixel_clk),
		.RESET_n   (RESET_n),
		.flip_i    (flip_i),
		.rif       (rif.timer_mp),
		.hsync_o   (hsync_o),
		.vsync_o   (vsync_o),
		.hblank_o  (hblank_o),
		.vblank_o  (vblank_o)
	);

	scroll_adder i_scroll_adder (
		.pixel_clk   (pixel_clk),
		.RESET_n     (RESET_n),
		.rif         (rif.user_mp),
		.scrl_wr_i   (scrl_wr_i),
		.scrl_sel_i  (scrl_sel_i),
		.scrl_data_i (scrl_data_i),
		.hscrl_o     (hscrl_o),
		.vscrl_o     (vscrl_o)
	);

	assign hpix_o = rif.hpix;	// unscrolled, for fg and sprites
	assign vpix_o = rif.vpix;

	// ======================================================================
	// pixel path, mix then colour
	// ======================================================================
	layer_priority i_layer_priority (
		.pixel_clk    (pixel_clk),
		.RESET_n      (RESET_n),
		.rif          (rif.user_mp),
		.fg_pix_i     (fg_pix_i),
		.sp_pix_i     (sp_pix_i),
		.bg_pix_i     (bg_pix_i),
		.mix_o        (mix_code),
		.mix_active_o (mix_active)
	);

	palette_ram i_palette_ram (
		.pixel_clk    (pixel_clk),
		.RESET_n      (RESET_n),
		.mix_i        (mix_code),
		.mix_active_i (mix_active),
		.pal_wr_i     (pal_wr_i),
		.pal_addr_i   (pal_addr_i),
		.pal_data_i   (pal_data_i),
		.red_o        (red_o),
		.green_o      (green_o),
		.blue_o       (blue_o)
	);

endmodule

// File: bench/video_model.svh
// reference model of the video back end for raster, scroll, priority and palette
`ifndef VIDEO_MODEL_SVH
`define VIDEO_MODEL_SVH

// horizontal position, line mirrored end to end when flipped
function automatic hcount_t ref_hpix(int hc, logic fl);
	return fl ? hcount_t'(H_TOTAL - 1 - hc) : hcount_t'(hc);
endfunction

// vertical position, low byte of the line
function automatic vpix_t ref_vpix(int vc, logic fl);
	vpix_t v;
	v = vpix_t'(vc);
	return fl ? (v ^ 8'hff) : v;	// every bit inverted on flip
endfunction

// {active, hblank, vblank, hsync, vsync} from raw counts
function automatic logic [4:0] ref_flags(int hc, int vc);
	logic [4:0] f;
	f[4] = (hc < H_ACTIVE) && (vc < V_ACTIVE);
	f[3] = (hc >= H_ACTIVE);
	f[2] = (vc >= V_ACTIVE);
	f[1] = (hc >= H_SYNC_START) && (hc < H_SYNC_END);	// end exclusive
	f[0] = (vc >= V_SYNC_START) && (vc < V_SYNC_END);
	return f;
endfunction

function automatic hcount_t ref_hscrl(hcount_t p, hcount_t s);
	return hcount_t'((int'(p) + int'(s)) % 512);
endfunction

function automatic vpix_t ref_vscrl(vpix_t p, vpix_t s);
	return vpix_t'((int'(p) + int'(s)) % 256);
endfunction

// fg over sprites over bg, fg index in bits 1:0, sprite index in 3:0
function automatic colour_code_u ref_mix(colour_code_u fg, colour_code_u sp, colour_code_u bg);
	if (fg[1:0] != 2'b00)
		return fg;
	if (sp[3:0] != 4'h0)
		return sp;
	return bg;
endfunction

// black whenever the pixel is outside the picture
function automatic pal_entry_t ref_rgb(pal_entry_t e, logic act);
	return act ? e : '0;
endfunction

`endif

// File: bench/video_core_tb.sv
// testbench for the video back end, raster, scroll, mixer, palette and flip checks
`timescale 1ns/1ps

module video_core_tb import video_timing_pkg::*, pixel_pkg::*; ();

	localparam int MAX_CYCLES = H_TOTAL * V_TOTAL * 3 + 1000;	// three frames plus slack

	logic         pixel_clk = 1'b0;
	logic         RESET_n;
	logic         flip_i;
	logic         scrl_wr_i;
	logic [1:0]   scrl_sel_i;
	logic [7:0]   scrl_data_i;
	logic         pal_wr_i;
	logic [7:0]   pal_addr_i;
	pal_entry_t   pal_data_i;
	colour_code_u fg_pix_i, sp_pix_i, bg_pix_i;
	hcount_t      hpix_o, hscrl_o;
	vpix_t        vpix_o, vscrl_o;
	gun_t         red_o, green_o, blue_o;
	logic         hsync_o, vsync_o, hblank_o, vblank_o;

	// ======================================================================
	// model state, advanced once per rising edge
	// ======================================================================
	int           hc = 0;		// tb pixel counter
	int           vc = 0;		// tb line counter
	int           frame = 0;
	int           cycles = 0;
	int           wr_cnt = 0;		// palette entries written so far
	logic         fl = 1'b0;		// flip of the current frame
	hcount_t      e_hpix = '0;
	vpix_t        e_vpix = '0;
	logic [4:0]   e_flags = '0;	// active, hblank, vblank, hsync, vsync
	hcount_t      sh_h = '0;		// scroll shadows
	vpix_t        sh_v = '0;
	colour_code_u e_mix = '0;
	logic         mix_act = 1'b0;
	pal_entry_t   e_rgb = '0;
	logic         rgb_ok = 1'b1;	// expected colour is defined
	pal_entry_t   pal_sh [PAL_DEPTH];	// shadow palette

	`include "video_model.svh"

	video_core i_video_core (.*);

	always #10 pixel_clk = ~pixel_clk;	// 20 ns period

	task automatic report_mismatch(string name, logic [31:0] got, logic [31:0] exp);
		$display("[ERROR] %0t ns %s got %0h expected %0h", $time, name, got, exp);
		$display("Errors found");
		$fatal(1, "stopped at first mismatch");
	endtask

	task automatic check_hcount(string name, hcount_t got, hcount_t exp);
		if (got !== exp)
			report_mismatch(name, 32'(got), 32'(exp));
	endtask

	task automatic check_vpix(string name, vpix_t got, vpix_t exp);
		if (got !== exp)
			report_mismatch(name, 32'(got), 32'(exp));
	endtask

	task automatic check_code(string name, colour_code_u got, colour_code_u exp);
		if (got !== exp)
			report_mismatch(name, 32'(got), 32'(exp));
	endtask

	task automatic check_colour(string name, pal_entry_t got, pal_entry_t exp);
		if (got !== exp)
			report_mismatch(name, 32'(got), 32'(exp));
	endtask

	task automatic check_bit(string name, logic got, logic exp);
		if (got !== exp)
			report_mismatch(name, 32'(got), 32'(exp));
	endtask

	// random layer codes, fg and sprites each see-through half the time
	task automatic drive_layers();
		fg_pix_i = 8'($urandom);
		sp_pix_i = 8'($urandom);
		bg_pix_i = 8'($urandom);
		if ($urandom % 2 == 0)
			fg_pix_i.fg_view.idx = '0;
		else if (fg_pix_i.fg_view.idx == '0)
			fg_pix_i.fg_view.idx = 2'd3;
		if ($urandom % 2 == 0)
			sp_pix_i.sp_view.idx = '0;
		else if (sp_pix_i.sp_view.idx == '0)
			sp_pix_i.sp_view.idx = 4'd9;
	endtask

	// scroll writes land in blanking only
	task automatic drive_scroll();
		scrl_wr_i   = (hblank_o || vblank_o) && ($urandom % 8 == 0);
		scrl_sel_i  = 2'($urandom % 3);
		scrl_data_i = 8'($urandom);
	endtask

	// ======================================================================
	// stimulus, driven on falling edges
	// ======================================================================
	initial begin
		void'($urandom(32'hf5d2));
		RESET_n     = 1'b0;
		flip_i      = 1'b0;
		scrl_wr_i   = 1'b0;
		scrl_sel_i  = '0;
		scrl_data_i = '0;
		pal_wr_i    = 1'b0;
		pal_addr_i  = '0;
		pal_data_i  = '0;
		fg_pix_i    = '0;
		sp_pix_i    = '0;
		bg_pix_i    = '0;
		repeat (2) @(posedge pixel_clk);
		@(negedge pixel_clk);
		RESET_n = 1'b1;
		// palette load while the raster already runs
		for (int a = 0; a < PAL_DEPTH; a++) begin
			pal_wr_i   = 1'b1;
			pal_addr_i = 8'(a);
			pal_data_i = pal_entry_t'(12'($urandom));
			drive_layers();
			@(negedge pixel_clk);
		end
		pal_wr_i = 1'b0;
		while (frame < 1 || vc < V_TOTAL / 2) begin	// unflipped up to mid frame 1
			drive_layers();
			drive_scroll();
			@(negedge pixel_clk);
		end
		flip_i = 1'b1;	// must wait for frame 2
		while (frame < 2 || vc < V_TOTAL / 2) begin
			drive_layers();
			drive_scroll();
			@(negedge pixel_clk);
		end
		$display("No errors");
		$finish;
	end

	// ======================================================================
	// checker, outputs seen as they were before the edge
	// ======================================================================
	always @(posedge pixel_clk) begin
		if (RESET_n) begin
			check_hcount("hpix_o", hpix_o, e_hpix);
			check_vpix("vpix_o", vpix_o, e_vpix);
			check_hcount("hscrl_o", hscrl_o, ref_hscrl(e_hpix, sh_h));
			check_vpix("vscrl_o", vscrl_o, ref_vscrl(e_vpix, sh_v));
			check_bit("hblank_o", hblank_o, e_flags[3]);
			check_bit("vblank_o", vblank_o, e_flags[2]);
			check_bit("hsync_o", hsync_o, e_flags[1]);
			check_bit("vsync_o", vsync_o, e_flags[0]);
			check_code("mix_code", i_video_core.mix_code, e_mix);
			if (rgb_ok)
				check_colour("rgb", {red_o, green_o, blue_o}, e_rgb);
			// pipeline, palette read sees entries from earlier edges
			rgb_ok  = !mix_act || (wr_cnt == PAL_DEPTH);
			e_rgb   = ref_rgb(pal_sh[e_mix], mix_act);
			mix_act = e_flags[4];
			e_mix   = ref_mix(fg_pix_i, sp_pix_i, bg_pix_i);
			if (hc == 0 && vc == 0)
				fl = flip_i;	// frame start
			e_hpix  = ref_hpix(hc, fl);
			e_vpix  = ref_vpix(vc, fl);
			e_flags = ref_flags(hc, vc);
			if (scrl_wr_i) begin
				case (scrl_sel_i)
					SCRL_SEL_H_LO: sh_h[7:0] = scrl_data_i;
					SCRL_SEL_H_HI: sh_h[8]   = scrl_data_i[0];
					SCRL_SEL_V:    sh_v      = scrl_data_i;
					default: ;
				endcase
			end
			if (pal_wr_i) begin
				pal_sh[pal_addr_i] = pal_data_i;
				wr_cnt++;
			end
			hc++;
			if (hc == H_TOTAL) begin	// next line
				hc = 0;
				vc++;
				if (vc == V_TOTAL) begin
					vc = 0;
					frame++;
				end
			end
		end
	end

	// run limit
	always @(posedge pixel_clk) begin
		cycles++;
		if (cycles > MAX_CYCLES) begin
			$display("Run did not finish within %0d cycles", MAX_CYCLES);
			$display("Errors found");
			$fatal(1, "timeout");
		end
	end

endmodule

// File: video_core.f
+incdir+bench
hw/video_timing_pkg.sv
hw/pixel_pkg.sv
hw/raster_if.sv
hw/raster_timer.sv
hw/scroll_adder.sv
hw/layer_priority.sv
hw/palette_ram.sv
hw/video_core.sv
bench/video_core_tb.sv
